/* audio_out_top.f */
+incdir+.
audio_pkg.sv
audio_apb_regs.sv
audio_clk_gen.sv
audio_frame_fsm.sv
audio_serializer.sv
audio_out_top.sv
tb_audio_out.sv

/* Makefile */
# Verilator build and run for the audio output block

VERILATOR ?= verilator
TOP       ?= tb_audio_out
FILELIST  ?= audio_out_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_audio_out.sv */
`timescale 1ns/1ps
`include "audio_defines.svh"

module tb_audio_out;
  import audio_pkg::*;

  localparam int TIMEOUT = 3000;  // clk cycles or polls per wait

  logic          clk;
  logic          rst;
  apb_req_t      apb_req;
  apb_rsp_t      apb_rsp;
  logic          mclk;
  logic          sclk;
  logic          lrclk;
  logic          sdin;
  integer        seed;
  int            errors;
  int            checks;
  int            tests;
  int            err_base;
  int            taken;        // Samples seen leaving the buffer
  int            repeats;      // Frames resent on underrun
  int            frames_seen;
  stereo_frame_t written_q[$];
  stereo_frame_t captured_q[$];
  int            avail_q[$];   // Samples written before each captured frame began
  stereo_frame_t last_sent;

  audio_out_top u_audio_out_top (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mclk    (mclk),
    .sclk    (sclk),
    .lrclk   (lrclk),
    .sdin    (sdin)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ======================================================================
  // Checks and reference
  // ======================================================================
  task automatic check_frame(input stereo_frame_t got, input stereo_frame_t exp,
                             input string what);
    checks++;
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input frame_count_t got, input frame_count_t exp,
                             input string what);
    checks++;
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // Oldest unsent sample if it was written before the frame began, otherwise the previous frame
  function automatic stereo_frame_t expected_frame(input int avail);
    if (taken < avail)
      return written_q[taken];
    return last_sent;
  endfunction

  task automatic finish_test(input string name);
    tests++;
    if (errors == err_base)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - err_base);
    err_base = errors;
  endtask

  // ======================================================================
  // APB and wait helpers
  // ======================================================================
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    int n;
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;  // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    #1;
    n = 0;
    while (!apb_rsp.pready && n < TIMEOUT)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!apb_rsp.pready)
    begin
      $display("APB write to %h never completed", addr);
      errors++;
    end
    err = apb_rsp.pslverr;
    @(posedge clk);  // Write commits here
    #1;
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    int n;
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    #1;
    n = 0;
    while (!apb_rsp.pready && n < TIMEOUT)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!apb_rsp.pready)
    begin
      $display("APB read from %h never completed", addr);
      errors++;
    end
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic write_sample(input stereo_frame_t s, output logic err);
    apb_write(`AUDIO_SAMPLE_ADDR, s, err);
    if (!err)
      written_q.push_back(s);
  endtask

  task automatic wait_buffer_empty();
    logic [31:0] st;
    logic        err;
    int          n;
    n = 0;
    apb_read(`AUDIO_STATUS_ADDR, st, err);
    while (st[0] && n < TIMEOUT)
    begin
      apb_read(`AUDIO_STATUS_ADDR, st, err);
      n++;
    end
    if (st[0])
    begin
      $display("sample buffer never emptied");
      errors++;
    end
  endtask

  task automatic wait_frames(input int count);
    int target;
    int n;
    target = frames_seen + count;
    n = 0;
    while (frames_seen < target && n < 4 * TIMEOUT)
    begin
      @(posedge clk);
      n++;
    end
    if (frames_seen < target)
    begin
      $display("no frame arrived on the DAC pins in time");
      errors++;
    end
  endtask

  task automatic wait_taken(input int count);
    int n;
    n = 0;
    while (taken < count && n < 16 * TIMEOUT)
    begin
      @(posedge clk);
      n++;
    end
    if (taken < count)
    begin
      $display("only %0d of %0d samples reached the DAC", taken, count);
      errors++;
    end
  endtask

  // Counts clk cycles between sclk toggles, keeping the last full one
  task automatic measure_half(output int cycles);
    logic prev;
    int   n;
    cycles = 0;
    for (int k = 0; k < 3; k++)
    begin
      prev = sclk;
      n = 0;
      while (sclk == prev && n < TIMEOUT)
      begin
        @(posedge clk);
        #1;
        n++;
      end
      if (sclk == prev)
      begin
        $display("sclk stopped toggling");
        errors++;
      end
      cycles = n;
    end
  endtask

  // ======================================================================
  // Frame capture and compare
  // ======================================================================
  initial
  begin : capture
    stereo_frame_t cur;
    int            nbit;
    int            avail;
    logic          sclk_d;
    cur    = '0;
    nbit   = 0;
    avail  = 0;
    sclk_d = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      if (sclk && !sclk_d)  // DAC samples on the sclk rise
      begin
        if (nbit == 0)
          avail = written_q.size();  // Samples already written when this frame began
        if (lrclk != (nbit >= 16))
        begin
          $display("mismatch at %0t: lrclk %0b in bit slot %0d", $time, lrclk, nbit);
          errors++;
        end
        if (nbit < 16)
          cur.right[15-nbit] = sdin;
        else
          cur.left[31-nbit] = sdin;
        nbit++;
        if (nbit == 32)
        begin
          captured_q.push_back(cur);
          avail_q.push_back(avail);
          frames_seen++;
          nbit = 0;
        end
      end
      sclk_d = sclk;
    end
  end

  initial
  begin : compare
    stereo_frame_t got;
    stereo_frame_t exp;
    int            avail;
    last_sent = '0;
    forever
    begin
      @(posedge clk);
      #2;
      while (captured_q.size() > 0)
      begin
        got   = captured_q.pop_front();
        avail = avail_q.pop_front();
        exp   = expected_frame(avail);
        check_frame(got, exp, "captured frame");
        if (taken < avail)
          taken++;
        else
          repeats++;
        last_sent = exp;
      end
    end
  end

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial
  begin : main
    logic [31:0]   rd;
    logic          err;
    stereo_frame_t s;
    int            half;
    logic          mclk_prev;
    int            toggles;
    seed        = 32'hcb551060;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    err_base    = 0;
    taken       = 0;
    repeats     = 0;
    frames_seen = 0;
    apb_req     = '0;
    rst         = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    apb_read(`AUDIO_CTRL_ADDR, rd, err);
    check_reg(rd, {16'h0, `AUDIO_DIV_RESET, 8'h00}, "CTRL after reset");
    apb_read(`AUDIO_STATUS_ADDR, rd, err);
    check_reg(rd, 32'h0, "STATUS after reset");
    for (int i = 0; i < 20; i++)
    begin
      @(posedge clk);
      #1;
      check_reg({28'h0, mclk, sclk, lrclk, sdin}, 32'h0, "DAC pins while idle");
    end
    finish_test("reset values");

    apb_write(`AUDIO_CTRL_ADDR, 32'h0000_5a00, err);
    check_reg({31'h0, err}, 32'h0, "pslverr on CTRL write");
    apb_read(`AUDIO_CTRL_ADDR, rd, err);
    check_reg(rd, 32'h0000_5a00, "CTRL read back");
    apb_read(4'hc, rd, err);
    check_reg({31'h0, err}, 32'h1, "pslverr on unmapped read");
    apb_write(4'hc, 32'h1, err);
    check_reg({31'h0, err}, 32'h1, "pslverr on unmapped write");
    finish_test("register access");

    s = stereo_frame_t'($random(seed));
    write_sample(s, err);  // Buffered before enable, so frame 0 is fresh
    check_reg({31'h0, err}, 32'h0, "pslverr on first sample");
    apb_write(`AUDIO_CTRL_ADDR, {16'h0, 8'd3, 8'h01}, err);
    for (int i = 1; i < 10; i++)
    begin
      wait_buffer_empty();
      s = stereo_frame_t'($random(seed));
      write_sample(s, err);
      check_reg({31'h0, err}, 32'h0, "pslverr on polled sample");
    end
    wait_taken(10);
    check_reg(repeats, 32'h0, "frames resent while samples were supplied");
    finish_test("sample stream");

    apb_write(`AUDIO_CTRL_ADDR, {16'h0, 8'd0, 8'h01}, err);
    measure_half(half);
    check_reg(half, 32'd1, "sclk half period at divider 0");
    apb_write(`AUDIO_CTRL_ADDR, {16'h0, 8'd5, 8'h01}, err);
    measure_half(half);
    check_reg(half, 32'd6, "sclk half period at divider 5");
    apb_write(`AUDIO_CTRL_ADDR, {16'h0, 8'd3, 8'h01}, err);
    toggles = 0;
    for (int i = 0; i < 8; i++)
    begin
      mclk_prev = mclk;
      @(posedge clk);
      #1;
      if (mclk !== mclk_prev)
        toggles++;
    end
    check_reg(toggles, 32'd8, "mclk toggles in 8 cycles");
    finish_test("divider");

    wait_frames(2);
    apb_read(`AUDIO_STATUS_ADDR, rd, err);
    check_reg({31'h0, rd[1]}, 32'h1, "underrun flag");
    wait_frames(1);
    repeat (10) @(posedge clk);  // Clear away from a frame load
    apb_write(`AUDIO_STATUS_ADDR, 32'h2, err);
    apb_read(`AUDIO_STATUS_ADDR, rd, err);
    check_reg({31'h0, rd[1]}, 32'h0, "underrun flag after clear");
    check_count(rd[31:16], frame_count_t'(written_q.size()), "frame count");
    finish_test("underrun");

    wait_frames(1);
    repeat (10) @(posedge clk);
    s = stereo_frame_t'($random(seed));
    write_sample(s, err);
    check_reg({31'h0, err}, 32'h0, "pslverr on sample to empty buffer");
    s = stereo_frame_t'($random(seed));
    apb_write(`AUDIO_SAMPLE_ADDR, s, err);  // Dropped, never queued
    check_reg({31'h0, err}, 32'h1, "pslverr on sample to full buffer");
    wait_frames(3);
    apb_read(`AUDIO_STATUS_ADDR, rd, err);
    check_count(rd[31:16], frame_count_t'(written_q.size()), "frame count after overflow");
    finish_test("overflow");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* audio_out_top.sv */
`timescale 1ns/1ps

module audio_out_top (
  input  logic                clk,
  input  logic                rst,
  input  audio_pkg::apb_req_t apb_req,
  output audio_pkg::apb_rsp_t apb_rsp,
  output logic                mclk,
  output logic                sclk,
  output logic                lrclk,
  output logic                sdin
);
  import audio_pkg::*;

  audio_ctrl_t   ctrl;
  stereo_frame_t buf_frame;
  stereo_frame_t load_frame;
  logic          buf_valid;
  logic          buf_take;
  logic          underrun_set;
  logic          frame_done;
  logic          bit_tick;
  logic          load;

  // ======================================================================
  // Register block and clocking
  // ======================================================================
  audio_apb_regs u_audio_apb_regs (
    .clk          (clk),
    .rst          (rst),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .ctrl         (ctrl),
    .buf_frame    (buf_frame),
    .buf_valid    (buf_valid),
    .buf_take     (buf_take),
    .underrun_set (underrun_set),
    .frame_done   (frame_done)
  );

  audio_clk_gen u_audio_clk_gen (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .mclk     (mclk),
    .sclk     (sclk),
    .bit_tick (bit_tick)
  );

  // ======================================================================
  // Frame path
  // ======================================================================
  audio_frame_fsm u_audio_frame_fsm (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .bit_tick     (bit_tick),
    .buf_frame    (buf_frame),
    .buf_valid    (buf_valid),
    .buf_take     (buf_take),
    .underrun_set (underrun_set),
    .frame_done   (frame_done),
    .load         (load),
    .load_frame   (load_frame),
    .lrclk        (lrclk)
  );

  audio_serializer u_audio_serializer (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .load_frame (load_frame),
    .bit_tick   (bit_tick),
    .sdin       (sdin)
  );

endmodule

/* audio_serializer.sv */
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_serializer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     load,
  input  audio_pkg::stereo_frame_t load_frame,
  input  logic                     bit_tick,
  output logic                     sdin
);

  localparam int FRAME_W = 2 * `AUDIO_SAMPLE_W;

  logic [FRAME_W-1:0] shreg;  // Right channel in the upper half

  // ======================================================================
  // Shift register, MSB first
  // ======================================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      shreg <= '0;
    else if (load)
      shreg <= {load_frame.right, load_frame.left};  // Load wins over a same-cycle tick
    else if (bit_tick)
      shreg <= {shreg[FRAME_W-2:0], 1'b0};
  end

  assign sdin = shreg[FRAME_W-1];

endmodule

/* audio_frame_fsm.sv */
`timescale 1ns/1ps

module audio_frame_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  audio_pkg::audio_ctrl_t   ctrl,
  input  logic                     bit_tick,
  input  audio_pkg::stereo_frame_t buf_frame,
  input  logic                     buf_valid,
  output logic                     buf_take,
  output logic                     underrun_set,
  output logic                     frame_done,
  output logic                     load,
  output audio_pkg::stereo_frame_t load_frame,
  output logic                     lrclk
);
  import audio_pkg::*;

  frame_state_t  state;
  bit_idx_t      bit_idx;
  stereo_frame_t last_frame;  // Resent on underrun
  logic          cur_fresh;   // Current frame came from the buffer
  logic          do_load;

  // ======================================================================
  // Frame load
  // ======================================================================
  // First frame loads at once, later ones wait for the 32nd tick
  assign do_load = ctrl.enable && (state == LOAD) && ((bit_idx == '0) || bit_tick);

  assign load         = do_load;
  assign buf_take     = do_load && buf_valid;
  assign underrun_set = do_load && !buf_valid;
  assign frame_done   = do_load && (bit_idx == 5'd31) && cur_fresh;
  assign load_frame   = buf_valid ? buf_frame : last_frame;
  assign lrclk        = bit_idx[4];  // Right for 0..15, left for 16..31

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= IDLE;
      bit_idx    <= '0;
      last_frame <= '0;
      cur_fresh  <= 1'b0;
    end
    else if (!ctrl.enable)
    begin
      state   <= IDLE;
      bit_idx <= '0;
    end
    else
    begin
      case (state)
        IDLE: state <= LOAD;
        LOAD:
        begin
          if (do_load)
          begin
            state      <= SHIFT;
            bit_idx    <= '0;
            last_frame <= load_frame;
            cur_fresh  <= buf_valid;
          end
        end
        SHIFT:
        begin
          if (bit_tick)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 5'd30)
              state <= LOAD;  // Last bit slot, reload on next tick
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* audio_clk_gen.sv */
`timescale 1ns/1ps

module audio_clk_gen (
  input  logic                   clk,
  input  logic                   rst,
  input  audio_pkg::audio_ctrl_t ctrl,
  output logic                   mclk,
  output logic                   sclk,
  output logic                   bit_tick
);
  import audio_pkg::*;

  clk_div_t cnt;  // Cycles left in this sclk half period

  // ======================================================================
  // Divider
  // ======================================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cnt  <= '0;
      mclk <= 1'b0;
      sclk <= 1'b0;
    end
    else if (!ctrl.enable)
    begin
      cnt  <= ctrl.clk_div;  // Start a full half period on enable
      mclk <= 1'b0;
      sclk <= 1'b0;
    end
    else
    begin
      mclk <= ~mclk;
      if (cnt == '0)
      begin
        cnt  <= ctrl.clk_div;
        sclk <= ~sclk;
      end
      else
      begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // High in the cycle whose closing edge drops sclk, so sdin moves with the fall
  assign bit_tick = ctrl.enable && sclk && (cnt == '0);

endmodule

/* audio_apb_regs.sv */
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_apb_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  audio_pkg::apb_req_t     apb_req,
  output audio_pkg::apb_rsp_t     apb_rsp,
  output audio_pkg::audio_ctrl_t  ctrl,
  output audio_pkg::stereo_frame_t buf_frame,
  output logic                    buf_valid,
  input  logic                    buf_take,
  input  logic                    underrun_set,
  input  logic                    frame_done
);
  import audio_pkg::*;

  logic         access;
  logic         wr;
  logic         hit_ctrl;
  logic         hit_sample;
  logic         hit_status;
  logic         sample_wr;
  logic         sample_err;
  logic         underrun;
  frame_count_t frame_count;
  logic [31:0]  rdata;

  // ======================================================================
  // Address decode
  // ======================================================================
  assign access     = apb_req.psel && apb_req.penable;  // Access phase
  assign wr         = access && apb_req.pwrite;
  assign hit_ctrl   = (apb_req.paddr == `AUDIO_CTRL_ADDR);
  assign hit_sample = (apb_req.paddr == `AUDIO_SAMPLE_ADDR);
  assign hit_status = (apb_req.paddr == `AUDIO_STATUS_ADDR);
  assign sample_wr  = wr && hit_sample && !buf_valid;
  assign sample_err = wr && hit_sample && buf_valid;    // Dropped write

  // ======================================================================
  // Registers
  // ======================================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ctrl.enable  <= 1'b0;
      ctrl.clk_div <= `AUDIO_DIV_RESET;
    end
    else if (wr && hit_ctrl)
    begin
      ctrl.enable  <= apb_req.pwdata[0];
      ctrl.clk_div <= apb_req.pwdata[15:8];
    end
  end

  // One-entry sample buffer
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      buf_valid <= 1'b0;
    else if (sample_wr)
      buf_valid <= 1'b1;
    else if (buf_take)
      buf_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (sample_wr)
      buf_frame <= apb_req.pwdata;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      underrun    <= 1'b0;
      frame_count <= '0;
    end
    else
    begin
      if (underrun_set)
        underrun <= 1'b1;  // Set wins over clear
      else if (wr && hit_status && apb_req.pwdata[1])
        underrun <= 1'b0;
      if (frame_done)
        frame_count <= frame_count + 1'b1;
    end
  end

  // ======================================================================
  // Read mux and response
  // ======================================================================
  always_comb
  begin
    rdata = '0;
    if (hit_ctrl)
      rdata = {16'b0, ctrl.clk_div, 7'b0, ctrl.enable};
    else if (hit_status)
      rdata = {frame_count, 14'b0, underrun, buf_valid};
  end

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = 1'b1;  // No wait states
  assign apb_rsp.pslverr = access && (sample_err || !(hit_ctrl || hit_sample || hit_status));

  // The FSM only takes a full buffer, and the take empties it
  ap_take_full: assert property (@(posedge clk) disable iff (rst)
    buf_take |-> buf_valid ##1 !buf_valid);

endmodule

/* audio_pkg.sv */
`include "audio_defines.svh"

package audio_pkg;

  typedef logic [`AUDIO_SAMPLE_W-1:0] audio_sample_t;
  typedef logic [7:0] clk_div_t;   // Half period minus one
  typedef logic [4:0] bit_idx_t;   // Bit slot within a frame
  typedef logic [15:0] frame_count_t;

  // Matches the SAMPLE register layout
  typedef struct packed {
    audio_sample_t left;   // Bits 31:16
    audio_sample_t right;  // Bits 15:0
  } stereo_frame_t;

  typedef struct packed {
    logic     enable;
    clk_div_t clk_div;
  } audio_ctrl_t;

  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`AUDIO_ADDR_W-1:0] paddr;
    logic [31:0]              pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {IDLE, LOAD, SHIFT} frame_state_t;

endpackage

/* audio_defines.svh */
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// ======================================================================
// Widths
// ======================================================================
`define AUDIO_SAMPLE_W 16  // One channel
`define AUDIO_ADDR_W 4     // APB byte address

// ======================================================================
// Register map
// ======================================================================
`define AUDIO_CTRL_ADDR 4'h0    // Enable and divider
`define AUDIO_SAMPLE_ADDR 4'h4  // Stereo sample, write only
`define AUDIO_STATUS_ADDR 4'h8  // Buffer, underrun, frame count

// sclk half period is this plus one clk cycles
`define AUDIO_DIV_RESET 8'd3

`endif
